// File: Bender.yml
package:
  name: internal_bus

sources:
  - include_dirs:
      - include
    files:
      - hdl/ibus_pkg.sv
      - hdl/state_manager.sv
      - hdl/mem_manager.sv
      - hdl/operand_regs.sv
      - hdl/alu.sv
      - hdl/internal_bus.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/internal_bus_chk.sv
      - bench/internal_bus_tb.sv

// File: bench/internal_bus_chk.sv
`timescale 1ns/1ps
`include "ibus_defs.svh"

module internal_bus_chk (
  input logic                  clk,
  input logic                  clk_oe,
  input logic                  reset,
  input logic                  read_q,
  input logic                  write_q,
  input logic                  read_dn,
  input logic                  write_dn,
  input logic [`ADDR_SIZE-1:0] addr_out,
  input logic                  halted
);

  // read by the testbench at the end of the run
  int fail_count = 0;

  // one transfer at a time
  a_one_strobe: assert property (@(posedge clk) disable iff (reset)
    !(read_q && write_q))
    else begin
      $error("read_q and write_q high together");
      fail_count++;
    end

  // read strobe and address held until the dn is taken
  a_read_hold: assert property (@(posedge clk) disable iff (reset)
    (read_q && !(clk_oe && read_dn)) |=> (read_q && $stable(addr_out)))
    else begin
      $error("read_q dropped or addr_out moved before read_dn");
      fail_count++;
    end

  a_write_hold: assert property (@(posedge clk) disable iff (reset)
    (write_q && !(clk_oe && write_dn)) |=> (write_q && $stable(addr_out)))
    else begin
      $error("write_q dropped or addr_out moved before write_dn");
      fail_count++;
    end

  // halted core stays off the bus
  a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
    halted |-> (!read_q && !write_q))
    else begin
      $error("bus strobe while halted");
      fail_count++;
    end

endmodule

// File: bench/internal_bus_tb.sv
`timescale 1ns/1ps
`include "ibus_defs.svh"

module internal_bus_tb;

  localparam int clk_half = 50;
  localparam int reset_cycles = 10;
  localparam int mem_words = 1024;
  localparam int num_tests = 6;
  // bus steps of the longest program (jumps)
  localparam int longest_steps = 19;
  localparam int watchdog_cycles = num_tests * longest_steps * 6;
  localparam int halt_limit = longest_steps * 6 * 2;

  logic                  clk;
  logic                  clk_oe = 1'b1;
  logic                  reset = 1'b1;
  logic [`ADDR_SIZE-1:0] base_addr = '0;
  logic [`ADDR_SIZE-1:0] base_addr_data = '0;
  logic [`DATA_SIZE-1:0] data_in = '0;
  logic                  read_dn = 1'b0;
  logic                  write_dn = 1'b0;
  logic [`ADDR_SIZE-1:0] addr_out;
  logic [`DATA_SIZE-1:0] data_out;
  logic                  read_q;
  logic                  write_q;
  ibus_pkg::state_t      state;
  logic                  halted;

  logic [`DATA_SIZE-1:0] mem [0:mem_words-1];
  logic [`DATA_SIZE-1:0] snap [0:mem_words-1];
  integer seed = 32'hab95_101b;
  logic pending = 1'b0;
  int lat = 0;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;

  initial clk = 1'b0;
  always #clk_half clk = ~clk;

  internal_bus u_internal_bus (
    .clk            (clk),
    .clk_oe         (clk_oe),
    .reset          (reset),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .data_in        (data_in),
    .read_dn        (read_dn),
    .write_dn       (write_dn),
    .addr_out       (addr_out),
    .data_out       (data_out),
    .read_q         (read_q),
    .write_q        (write_q),
    .state          (state),
    .halted         (halted)
  );

  bind internal_bus internal_bus_chk u_internal_bus_chk (
    .clk      (clk),
    .clk_oe   (clk_oe),
    .reset    (reset),
    .read_q   (read_q),
    .write_q  (write_q),
    .read_dn  (read_dn),
    .write_dn (write_dn),
    .addr_out (addr_out),
    .halted   (halted)
  );

  // memory answers a strobe after 0 to 3 cycles and holds dn until the strobe drops
  always @(posedge clk) begin
    #1;
    if (reset) begin
      read_dn = 1'b0;
      write_dn = 1'b0;
      data_in = '0;
      pending = 1'b0;
    end else if (read_dn || write_dn) begin
      if (!read_q && !write_q) begin
        read_dn = 1'b0;
        write_dn = 1'b0;
        data_in = '0;
      end
    end else if (read_q || write_q) begin
      if (!pending) begin
        pending = 1'b1;
        lat = $random(seed) & 3;
      end
      if (lat == 0) begin
        pending = 1'b0;
        if (read_q) begin
          data_in = mem[addr_out];
          read_dn = 1'b1;
        end else begin
          mem[addr_out] = data_out;
          write_dn = 1'b1;
        end
      end else begin
        lat = lat - 1;
      end
    end
  end

  function automatic logic [31:0] alu_cmd(input logic [3:0] code, input logic [7:0] dst,
                                          input logic [7:0] s1, input logic [7:0] s0);
    return {code, dst, s1, s0, 4'h0};
  endfunction

  function automatic logic [31:0] jump_cmd(input logic [3:0] code, input logic [7:0] target);
    return {code, 20'h0, target};
  endfunction

  function automatic logic [31:0] fill_word(input int addr);
    logic [15:0] a;
    a = addr[15:0];
    return {~a, a} ^ 32'h5a5a_0000;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic fill_memory();
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = fill_word(i);
    end
  endtask

  task automatic start_run(input logic [15:0] code_base, input logic [15:0] data_base);
    reset = 1'b1;
    clk_oe = 1'b1;
    base_addr = code_base;
    base_addr_data = data_base;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic wait_halted(input string name);
    int n;
    n = 0;
    while (!halted && n < halt_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!halted) begin
      errors++;
      $display("%s: core did not halt within %0d cycles", name, halt_limit);
    end
  endtask

  task automatic wait_bus_state(input ibus_pkg::state_t st, input string name);
    int n;
    n = 0;
    while (!(state == st && (read_q || write_q)) && n < halt_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!(state == st && (read_q || write_q))) begin
      errors++;
      $display("%s: bus never reached the expected step", name);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic add_sub_results();
    int e0;
    logic [31:0] a;
    logic [31:0] b;
    e0 = errors;
    a = $random(seed);
    b = $random(seed);
    fill_memory();
    mem[16'h0100] = a;
    mem[16'h0101] = b;
    mem[16'h0000] = alu_cmd(`CMD_ADD, 8'd2, 8'd0, 8'd1);
    mem[16'h0001] = alu_cmd(`CMD_SUB, 8'd3, 8'd0, 8'd1);
    mem[16'h0002] = alu_cmd(`CMD_SUB, 8'd4, 8'd1, 8'd0);
    mem[16'h0003] = jump_cmd(`CMD_STOP, 8'd0);
    start_run(16'h0000, 16'h0100);
    wait_halted("add_sub");
    check_value("mem_sum", a + b, mem[16'h0102]);
    check_value("mem_diff", a - b, mem[16'h0103]);
    check_value("mem_diff_rev", b - a, mem[16'h0104]);
    finish_test("add_sub", e0);
  endtask

  task automatic logic_and_move();
    int e0;
    logic [31:0] a;
    logic [31:0] b;
    e0 = errors;
    a = $random(seed);
    b = $random(seed);
    fill_memory();
    mem[16'h0200] = a;
    mem[16'h0201] = b;
    mem[16'h0040] = alu_cmd(`CMD_AND, 8'd2, 8'd0, 8'd1);
    mem[16'h0041] = alu_cmd(`CMD_XOR, 8'd3, 8'd0, 8'd1);
    mem[16'h0042] = alu_cmd(`CMD_MOV, 8'd4, 8'd1, 8'd0);
    mem[16'h0043] = jump_cmd(`CMD_STOP, 8'd0);
    start_run(16'h0040, 16'h0200);
    wait_halted("and_xor_mov");
    check_value("mem_and", a & b, mem[16'h0202]);
    check_value("mem_xor", a ^ b, mem[16'h0203]);
    check_value("mem_mov", b, mem[16'h0204]);
    finish_test("and_xor_mov", e0);
  endtask

  task automatic jump_flow();
    int e0;
    logic [31:0] a;
    logic [31:0] b;
    e0 = errors;
    a = 32'h0000_1234;
    b = 32'h8000_0101;
    fill_memory();
    mem[16'h0280] = a;
    mem[16'h0281] = b;
    // zero result lets the jz skip the move at 2
    mem[16'h0080] = alu_cmd(`CMD_SUB, 8'd2, 8'd0, 8'd0);
    mem[16'h0081] = jump_cmd(`CMD_JZ, 8'd3);
    mem[16'h0082] = alu_cmd(`CMD_MOV, 8'd5, 8'd1, 8'd0);
    mem[16'h0083] = alu_cmd(`CMD_ADD, 8'd6, 8'd0, 8'd1);
    mem[16'h0084] = jump_cmd(`CMD_JZ, 8'd6);
    mem[16'h0085] = alu_cmd(`CMD_MOV, 8'd7, 8'd0, 8'd0);
    mem[16'h0086] = jump_cmd(`CMD_JMP, 8'd8);
    mem[16'h0087] = jump_cmd(`CMD_STOP, 8'd0);
    mem[16'h0088] = alu_cmd(`CMD_MOV, 8'd9, 8'd1, 8'd0);
    // back over the move to the stop
    mem[16'h0089] = jump_cmd(`CMD_JMP, 8'd7);
    start_run(16'h0080, 16'h0280);
    wait_halted("jumps");
    check_value("mem_zero_diff", 32'h0, mem[16'h0282]);
    check_value("mem_skipped_mov", fill_word(16'h0285), mem[16'h0285]);
    check_value("mem_sum", a + b, mem[16'h0286]);
    check_value("mem_mov_after_jz", a, mem[16'h0287]);
    check_value("mem_mov_after_jmp", b, mem[16'h0289]);
    finish_test("jumps", e0);
  endtask

  task automatic halt_stays_quiet();
    int e0;
    int bad;
    int changed;
    logic [31:0] a;
    logic [31:0] b;
    e0 = errors;
    bad = 0;
    changed = 0;
    a = $random(seed);
    b = $random(seed);
    fill_memory();
    mem[16'h0300] = a;
    mem[16'h0301] = b;
    mem[16'h00c0] = alu_cmd(`CMD_ADD, 8'd2, 8'd0, 8'd1);
    mem[16'h00c1] = jump_cmd(`CMD_STOP, 8'd0);
    start_run(16'h00c0, 16'h0300);
    wait_halted("halt");
    check_value("mem_sum", a + b, mem[16'h0302]);
    for (int i = 0; i < mem_words; i++) begin
      snap[i] = mem[i];
    end
    repeat (20) begin
      @(posedge clk);
      #1;
      if (read_q || write_q || !halted) begin
        bad++;
      end
      // idle bus outputs are zero
      check_value("addr_out", 32'h0, 32'(addr_out));
      check_value("data_out", 32'h0, data_out);
    end
    for (int i = 0; i < mem_words; i++) begin
      if (mem[i] !== snap[i]) begin
        changed++;
      end
    end
    check_value("bus_cycles_after_stop", 0, bad);
    check_value("mem_words_changed", 0, changed);
    finish_test("halt", e0);
  endtask

  task automatic clock_enable_freeze();
    int e0;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    ibus_pkg::state_t held_state;
    logic [15:0] held_addr;
    e0 = errors;
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    fill_memory();
    mem[16'h0340] = a;
    mem[16'h0341] = b;
    mem[16'h0342] = c;
    mem[16'h0100] = alu_cmd(`CMD_ADD, 8'd3, 8'd0, 8'd1);
    mem[16'h0101] = alu_cmd(`CMD_SUB, 8'd4, 8'd0, 8'd1);
    mem[16'h0102] = alu_cmd(`CMD_XOR, 8'd5, 8'd0, 8'd2);
    mem[16'h0103] = jump_cmd(`CMD_STOP, 8'd0);
    start_run(16'h0100, 16'h0340);
    wait_bus_state(ibus_pkg::ST_READ_S0, "clk_oe");
    clk_oe = 1'b0;
    held_state = state;
    held_addr = addr_out;
    repeat (15) begin
      @(posedge clk);
      #1;
      check_value("state", 32'(held_state), 32'(state));
      check_value("addr_out", 32'(held_addr), 32'(addr_out));
    end
    clk_oe = 1'b1;
    wait_halted("clk_oe");
    check_value("mem_sum", a + b, mem[16'h0343]);
    check_value("mem_diff", a - b, mem[16'h0344]);
    check_value("mem_xor", a ^ c, mem[16'h0345]);
    finish_test("clk_oe", e0);
  endtask

  task automatic load_reset_program(input logic [31:0] a, input logic [31:0] b);
    fill_memory();
    mem[16'h0380] = a;
    mem[16'h0381] = b;
    mem[16'h0140] = alu_cmd(`CMD_ADD, 8'd3, 8'd0, 8'd1);
    mem[16'h0141] = alu_cmd(`CMD_AND, 8'd4, 8'd0, 8'd1);
    mem[16'h0142] = alu_cmd(`CMD_SUB, 8'd5, 8'd1, 8'd0);
    mem[16'h0143] = jump_cmd(`CMD_STOP, 8'd0);
  endtask

  task automatic reset_mid_program();
    int e0;
    logic [31:0] a;
    logic [31:0] b;
    e0 = errors;
    a = $random(seed);
    b = $random(seed);
    load_reset_program(a, b);
    start_run(16'h0140, 16'h0380);
    wait_bus_state(ibus_pkg::ST_WRITE_D, "reset");
    reset = 1'b1;
    @(posedge clk);
    #1;
    check_value("state", 32'(ibus_pkg::ST_FETCH), 32'(state));
    check_value("read_q", 32'h0, 32'(read_q));
    check_value("write_q", 32'h0, 32'(write_q));
    load_reset_program(a, b);
    start_run(16'h0140, 16'h0380);
    wait_halted("reset");
    check_value("mem_sum", a + b, mem[16'h0383]);
    check_value("mem_and", a & b, mem[16'h0384]);
    check_value("mem_diff", b - a, mem[16'h0385]);
    finish_test("reset", e0);
  endtask

  initial begin
    fill_memory();
    add_sub_results();
    logic_and_move();
    jump_flow();
    halt_stays_quiet();
    clock_enable_freeze();
    reset_mid_program();
    check_value("assertion_failures", 0, u_internal_bus.u_internal_bus_chk.fail_count);
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // limit from the test count and the longest program
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

// File: files.f
+incdir+include
hdl/ibus_pkg.sv
hdl/state_manager.sv
hdl/mem_manager.sv
hdl/operand_regs.sv
hdl/alu.sv
hdl/internal_bus.sv
bench/internal_bus_chk.sv
bench/internal_bus_tb.sv

// File: hdl/alu.sv
`timescale 1ns/1ps
`include "ibus_defs.svh"

module alu (
  input  logic                  clk,
  input  logic                  clk_oe,
  input  logic                  reset,
  input  ibus_pkg::state_t      state,
  input  ibus_pkg::command_t    command,
  input  logic [`DATA_SIZE-1:0] src1,
  input  logic [`DATA_SIZE-1:0] src0,
  output logic [`DATA_SIZE-1:0] result,
  output logic                  zero
);

  logic [`DATA_SIZE-1:0] alu_out;

  // add and sub wrap at the word width
  always_comb begin
    case (command.alu.code)
      ibus_pkg::OP_ADD: alu_out = src1 + src0;
      ibus_pkg::OP_SUB: alu_out = src1 - src0;
      ibus_pkg::OP_AND: alu_out = src1 & src0;
      ibus_pkg::OP_XOR: alu_out = src1 ^ src0;
      // mov passes the first source
      default: alu_out = src1;
    endcase
  end

  // zero flag is kept for a later jz
  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      zero <= 1'b0;
    end else if (clk_oe && (state == ibus_pkg::ST_EXEC)) begin
      result <= alu_out;
      zero <= (alu_out == '0);
    end
  end

endmodule

// File: hdl/ibus_pkg.sv
`include "ibus_defs.svh"

package ibus_pkg;

  // sequencer steps
  typedef enum logic [2:0] {
    ST_FETCH   = 3'd0,
    ST_READ_S1 = 3'd1,
    ST_READ_S0 = 3'd2,
    ST_EXEC    = 3'd3,
    ST_WRITE_D = 3'd4,
    ST_HALT    = 3'd5
  } state_t;

  typedef enum logic [3:0] {
    OP_ADD  = `CMD_ADD,
    OP_SUB  = `CMD_SUB,
    OP_AND  = `CMD_AND,
    OP_XOR  = `CMD_XOR,
    OP_MOV  = `CMD_MOV,
    OP_JMP  = `CMD_JMP,
    OP_JZ   = `CMD_JZ,
    OP_STOP = `CMD_STOP
  } cmd_code_t;

  // arithmetic and move commands
  typedef struct packed {
    cmd_code_t             code;
    logic [`OFS_SIZE-1:0]  dst;
    logic [`OFS_SIZE-1:0]  src1;
    logic [`OFS_SIZE-1:0]  src0;
    logic [3:0]            spare;
  } alu_form_t;

  // flow commands, target is a code offset
  typedef struct packed {
    cmd_code_t             code;
    logic [19:0]           spare;
    logic [`OFS_SIZE-1:0]  target;
  } jump_form_t;

  typedef union packed {
    alu_form_t  alu;
    jump_form_t jmp;
  } command_t;

endpackage

// File: hdl/internal_bus.sv
`timescale 1ns/1ps
`include "ibus_defs.svh"

module internal_bus (
  input  logic                  clk,
  input  logic                  clk_oe,
  input  logic                  reset,
  input  logic [`ADDR_SIZE-1:0] base_addr,
  input  logic [`ADDR_SIZE-1:0] base_addr_data,
  input  logic [`DATA_SIZE-1:0] data_in,
  input  logic                  read_dn,
  input  logic                  write_dn,
  output logic [`ADDR_SIZE-1:0] addr_out,
  output logic [`DATA_SIZE-1:0] data_out,
  output logic                  read_q,
  output logic                  write_q,
  output ibus_pkg::state_t      state,
  output logic                  halted
);

  logic [`OFS_SIZE-1:0]  ip;
  ibus_pkg::command_t    command;
  logic [`DATA_SIZE-1:0] src1;
  logic [`DATA_SIZE-1:0] src0;
  logic [`DATA_SIZE-1:0] result;
  logic                  zero;
  logic                  step_done;

  state_manager u_state_manager (
    .clk       (clk),
    .clk_oe    (clk_oe),
    .reset     (reset),
    .step_done (step_done),
    .command   (command),
    .zero      (zero),
    .state     (state),
    .ip        (ip),
    .halted    (halted)
  );

  // single bus master of the core
  mem_manager u_mem_manager (
    .clk            (clk),
    .clk_oe         (clk_oe),
    .reset          (reset),
    .state          (state),
    .ip             (ip),
    .command        (command),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .result         (result),
    .read_dn        (read_dn),
    .write_dn       (write_dn),
    .read_q         (read_q),
    .write_q        (write_q),
    .addr_out       (addr_out),
    .data_out       (data_out),
    .step_done      (step_done)
  );

  operand_regs u_operand_regs (
    .clk       (clk),
    .clk_oe    (clk_oe),
    .reset     (reset),
    .state     (state),
    .step_done (step_done),
    .data_in   (data_in),
    .command   (command),
    .src1      (src1),
    .src0      (src0)
  );

  alu u_alu (
    .clk     (clk),
    .clk_oe  (clk_oe),
    .reset   (reset),
    .state   (state),
    .command (command),
    .src1    (src1),
    .src0    (src0),
    .result  (result),
    .zero    (zero)
  );

endmodule

// File: hdl/mem_manager.sv
`timescale 1ns/1ps
`include "ibus_defs.svh"

module mem_manager (
  input  logic                  clk,
  input  logic                  clk_oe,
  input  logic                  reset,
  input  ibus_pkg::state_t      state,
  input  logic [`OFS_SIZE-1:0]  ip,
  input  ibus_pkg::command_t    command,
  input  logic [`ADDR_SIZE-1:0] base_addr,
  input  logic [`ADDR_SIZE-1:0] base_addr_data,
  input  logic [`DATA_SIZE-1:0] result,
  input  logic                  read_dn,
  input  logic                  write_dn,
  output logic                  read_q,
  output logic                  write_q,
  output logic [`ADDR_SIZE-1:0] addr_out,
  output logic [`DATA_SIZE-1:0] data_out,
  output logic                  step_done
);

  logic [`OFS_SIZE-1:0]  ofs;
  logic [`ADDR_SIZE-1:0] fetch_addr;
  logic [`ADDR_SIZE-1:0] data_addr;
  logic                  is_read;
  logic                  is_write;
  // step of the current state already served, wait for the state to move on
  logic                  served;

  // data offset for the current bus step
  always_comb begin
    case (state)
      ibus_pkg::ST_READ_S1: ofs = command.alu.src1;
      ibus_pkg::ST_READ_S0: ofs = command.alu.src0;
      default: ofs = command.alu.dst;
    endcase
  end

  assign fetch_addr = base_addr + {{(`ADDR_SIZE - `OFS_SIZE){1'b0}}, ip};
  assign data_addr = base_addr_data + {{(`ADDR_SIZE - `OFS_SIZE){1'b0}}, ofs};

  assign is_read = (state == ibus_pkg::ST_FETCH) ||
                   (state == ibus_pkg::ST_READ_S1) ||
                   (state == ibus_pkg::ST_READ_S0);
  assign is_write = (state == ibus_pkg::ST_WRITE_D);

  // dn sampled at this enabled edge
  assign step_done = clk_oe & ((read_q & read_dn) | (write_q & write_dn));

  always_ff @(posedge clk) begin
    if (reset) begin
      read_q <= 1'b0;
      write_q <= 1'b0;
      addr_out <= '0;
      data_out <= '0;
      served <= 1'b0;
    end else if (clk_oe) begin
      served <= step_done;
      if (step_done) begin
        // bus goes idle and zero
        read_q <= 1'b0;
        write_q <= 1'b0;
        addr_out <= '0;
        data_out <= '0;
      end else if (!read_q && !write_q && !served && (is_read || is_write)) begin
        read_q <= is_read;
        write_q <= is_write;
        addr_out <= (state == ibus_pkg::ST_FETCH) ? fetch_addr : data_addr;
        data_out <= is_write ? result : '0;
      end
    end
  end

endmodule

// File: hdl/operand_regs.sv
`timescale 1ns/1ps
`include "ibus_defs.svh"

module operand_regs (
  input  logic                  clk,
  input  logic                  clk_oe,
  input  logic                  reset,
  input  ibus_pkg::state_t      state,
  input  logic                  step_done,
  input  logic [`DATA_SIZE-1:0] data_in,
  output ibus_pkg::command_t    command,
  output logic [`DATA_SIZE-1:0] src1,
  output logic [`DATA_SIZE-1:0] src0
);

  // the state of the finished read picks the target register
  always_ff @(posedge clk) begin
    if (reset) begin
      command <= '0;
      src1 <= '0;
      src0 <= '0;
    end else if (clk_oe && step_done) begin
      case (state)
        ibus_pkg::ST_FETCH: begin
          command <= ibus_pkg::command_t'(data_in);
        end
        ibus_pkg::ST_READ_S1: begin
          src1 <= data_in;
        end
        ibus_pkg::ST_READ_S0: begin
          src0 <= data_in;
        end
        // write completions leave the buffers alone
        default: begin
        end
      endcase
    end
  end

endmodule

// File: hdl/state_manager.sv
`timescale 1ns/1ps
`include "ibus_defs.svh"

module state_manager (
  input  logic                 clk,
  input  logic                 clk_oe,
  input  logic                 reset,
  input  logic                 step_done,
  input  ibus_pkg::command_t   command,
  input  logic                 zero,
  output ibus_pkg::state_t     state,
  output logic [`OFS_SIZE-1:0] ip,
  output logic                 halted
);

  // bus step finished one edge ago, so the fetched command is already held
  logic                 step_seen;
  ibus_pkg::state_t     next_state;
  logic [`OFS_SIZE-1:0] next_ip;
  logic [`OFS_SIZE-1:0] ip_inc;

  assign ip_inc = ip + 1'b1;
  assign halted = (state == ibus_pkg::ST_HALT);

  always_comb begin
    next_state = state;
    next_ip = ip;
    case (state)
      ibus_pkg::ST_FETCH: begin
        if (step_seen) begin
          case (command.alu.code)
            ibus_pkg::OP_ADD, ibus_pkg::OP_SUB, ibus_pkg::OP_AND,
            ibus_pkg::OP_XOR, ibus_pkg::OP_MOV: begin
              next_state = ibus_pkg::ST_READ_S1;
            end
            ibus_pkg::OP_JMP: next_ip = command.jmp.target;
            ibus_pkg::OP_JZ: next_ip = zero ? command.jmp.target : ip_inc;
            ibus_pkg::OP_STOP: next_state = ibus_pkg::ST_HALT;
            // unknown codes are skipped
            default: next_ip = ip_inc;
          endcase
        end
      end
      ibus_pkg::ST_READ_S1: begin
        if (step_seen) begin
          // mov has a single source
          if (command.alu.code == ibus_pkg::OP_MOV) begin
            next_state = ibus_pkg::ST_EXEC;
          end else begin
            next_state = ibus_pkg::ST_READ_S0;
          end
        end
      end
      ibus_pkg::ST_READ_S0: begin
        if (step_seen) begin
          next_state = ibus_pkg::ST_EXEC;
        end
      end
      // one enabled cycle only
      ibus_pkg::ST_EXEC: next_state = ibus_pkg::ST_WRITE_D;
      ibus_pkg::ST_WRITE_D: begin
        if (step_seen) begin
          next_state = ibus_pkg::ST_FETCH;
          next_ip = ip_inc;
        end
      end
      ibus_pkg::ST_HALT: next_state = ibus_pkg::ST_HALT;
      default: next_state = ibus_pkg::ST_FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ibus_pkg::ST_FETCH;
      ip <= '0;
      step_seen <= 1'b0;
    end else if (clk_oe) begin
      state <= next_state;
      ip <= next_ip;
      step_seen <= step_done;
    end
  end

endmodule

// File: include/ibus_defs.svh
`ifndef IBUS_DEFS_SVH
`define IBUS_DEFS_SVH

// external bus widths
`define ADDR_SIZE 16
`define DATA_SIZE 32

// operand offset and jump target inside a command word
`define OFS_SIZE 8

// opcode values in the top nibble of a command
`define CMD_ADD  4'h1
`define CMD_SUB  4'h2
`define CMD_AND  4'h3
`define CMD_XOR  4'h4
`define CMD_MOV  4'h5
`define CMD_JMP  4'h8
`define CMD_JZ   4'h9
`define CMD_STOP 4'hf

`endif
